// ==== verilog/sram_pkg.sv ====
package sram_pkg;

  // Array contents after reset
  typedef enum logic [1:0] {
    INIT_X    = 2'd0, // Unknown contents
    INIT_ADDR = 2'd1, // Each word holds its own global word address
    INIT_ZERO = 2'd2  // No storage, every read returns zero
  } init_mode_e;

  // Per-bank response FIFO, 4 entries
  localparam int RESP_DEPTH_LOG2 = 2;

  // Read-order queue, 8 entries
  // Must cover all reads that can be in flight across the banks
  localparam int ORDER_DEPTH_LOG2 = 3;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
  parameter int  ADDR_WIDTH = 2,
  parameter type entry_t    = logic [7:0]
) (
  input  logic   clk,
  input  logic   rst_n,

  input  logic   w_inc,
  input  entry_t w_data,
  output logic   w_full,
  output logic   w_half_full,

  input  logic   r_inc,
  output logic   r_empty,
  output entry_t r_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  entry_t              mem [DEPTH];
  logic [ADDR_WIDTH:0] w_ptr;
  logic [ADDR_WIDTH:0] r_ptr;
  logic [ADDR_WIDTH:0] count;

  // Pointers carry one extra wrap bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (w_inc) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (r_inc) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_inc) begin
      mem[w_ptr[ADDR_WIDTH-1:0]] <= w_data;
    end
  end

  assign count       = w_ptr - r_ptr;
  assign w_full      = count[ADDR_WIDTH];
  assign w_half_full = count >= (ADDR_WIDTH + 1)'(DEPTH / 2);
  assign r_empty     = (count == '0);
  assign r_data      = mem[r_ptr[ADDR_WIDTH-1:0]]; // Head shown without a strobe

  no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) w_inc |-> !w_full
  );

  no_read_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n) r_inc |-> !r_empty
  );

endmodule

// ==== verilog/sram_bank.sv ====
`timescale 1ns/1ns

module sram_bank #(
  parameter int                  LOCAL_ADDR_WIDTH = 4,
  parameter int                  BANK_BITS        = 2,
  parameter int                  BANK_INDEX       = 0,
  parameter int                  DATA_WIDTH       = 16,
  parameter sram_pkg::init_mode_e INIT_MODE       = sram_pkg::INIT_ADDR
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  logic [LOCAL_ADDR_WIDTH-1:0] cmd_addr,
  input  logic                        cmd_wr_en,
  input  logic [DATA_WIDTH-1:0]       cmd_wr_data,
  input  logic [DATA_WIDTH/8-1:0]     cmd_wr_strb,

  output logic                        resp_valid,
  input  logic                        resp_ready,
  output logic [DATA_WIDTH-1:0]       resp_rd_data
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int WORDS      = 1 << LOCAL_ADDR_WIDTH;

  typedef logic [DATA_WIDTH-1:0] word_t;

  logic  rd_fire;
  logic  wr_fire;
  logic  fifo_half_full;
  logic  fifo_empty;
  word_t fifo_w_data;
  word_t fifo_r_data;

  assign rd_fire = cmd_valid && cmd_ready && !cmd_wr_en;
  assign wr_fire = cmd_valid && cmd_ready && cmd_wr_en;

  sync_fifo #(
    .ADDR_WIDTH (sram_pkg::RESP_DEPTH_LOG2),
    .entry_t    (word_t)
  ) i_resp_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_inc       (rd_fire),
    .w_data      (fifo_w_data),
    .w_full      (),
    .w_half_full (fifo_half_full),
    .r_inc       (resp_valid && resp_ready),
    .r_empty     (fifo_empty),
    .r_data      (fifo_r_data)
  );

  // Stop at half full so a queued read never overruns the FIFO
  assign cmd_ready    = !fifo_half_full;
  assign resp_valid   = !fifo_empty;
  assign resp_rd_data = fifo_r_data;

  if (INIT_MODE == sram_pkg::INIT_ZERO) begin : g_zero
    assign fifo_w_data = '0; // No array, writes are dropped
  end else begin : g_array
    word_t mem [WORDS];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        for (int i = 0; i < WORDS; i++) begin
          // Global address puts the bank index in the low bits
          mem[i] <= (INIT_MODE == sram_pkg::INIT_ADDR) ?
                    DATA_WIDTH'((i << BANK_BITS) + BANK_INDEX) : 'x;
        end
      end else if (wr_fire) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (cmd_wr_strb[b]) begin
            mem[cmd_addr][b*8 +: 8] <= cmd_wr_data[b*8 +: 8];
          end
        end
      end
    end

    assign fifo_w_data = mem[cmd_addr]; // Sees writes from the previous edge
  end

  // Accepted read is queued by the next edge
  rd_then_valid: assert property (
    @(posedge clk) disable iff (!rst_n) rd_fire |=> resp_valid
  );

endmodule

// ==== verilog/bank_router.sv ====
`timescale 1ns/1ns

module bank_router #(
  parameter int ADDR_WIDTH = 6,
  parameter int BANK_BITS  = 2,
  parameter int DATA_WIDTH = 16
) (
  input  logic                            cmd_valid,
  output logic                            cmd_ready,
  input  logic [ADDR_WIDTH-1:0]           cmd_addr,
  input  logic                            cmd_wr_en,

  output logic [(1 << BANK_BITS)-1:0]     bank_cmd_valid,
  input  logic [(1 << BANK_BITS)-1:0]     bank_cmd_ready,
  output logic [ADDR_WIDTH-BANK_BITS-1:0] bank_cmd_addr,

  output logic                            order_push,
  output logic [BANK_BITS-1:0]            order_bank,
  input  logic                            order_ready
);

  logic [BANK_BITS-1:0] sel;
  logic                 order_ok;
  logic                 sel_ready;

  // Byte strobes need a whole number of bytes per word
  if (DATA_WIDTH % 8 != 0) begin : g_bad_width
    $error("DATA_WIDTH must be a multiple of 8");
  end
  if (ADDR_WIDTH <= BANK_BITS) begin : g_bad_addr
    $error("ADDR_WIDTH must exceed BANK_BITS");
  end

  assign sel           = cmd_addr[BANK_BITS-1:0];         // Low bits interleave
  assign bank_cmd_addr = cmd_addr[ADDR_WIDTH-1:BANK_BITS];

  // Reads need a free slot in the order queue, writes do not
  assign order_ok  = cmd_wr_en || order_ready;
  assign sel_ready = bank_cmd_ready[sel];

  always_comb begin
    bank_cmd_valid = '0;
    if (cmd_valid && order_ok) begin
      bank_cmd_valid[sel] = 1'b1;
    end
  end

  assign cmd_ready  = sel_ready && order_ok;
  assign order_push = cmd_valid && !cmd_wr_en && sel_ready && order_ready;
  assign order_bank = sel;

endmodule

// ==== verilog/resp_merger.sv ====
`timescale 1ns/1ns

module resp_merger #(
  parameter int BANK_BITS  = 2,
  parameter int DATA_WIDTH = 16
) (
  input  logic                                          clk,
  input  logic                                          rst_n,

  input  logic                                          order_push,
  input  logic [BANK_BITS-1:0]                          order_bank,
  output logic                                          order_ready,

  input  logic [(1 << BANK_BITS)-1:0]                   bank_resp_valid,
  output logic [(1 << BANK_BITS)-1:0]                   bank_resp_ready,
  input  logic [(1 << BANK_BITS)-1:0][DATA_WIDTH-1:0]   bank_resp_rd_data,

  output logic                                          resp_valid,
  input  logic                                          resp_ready,
  output logic [DATA_WIDTH-1:0]                         resp_rd_data
);

  localparam int NUM_BANKS = 1 << BANK_BITS;

  typedef logic [BANK_BITS-1:0] bank_idx_t;

  bank_idx_t head;
  logic      order_full;
  logic      order_empty;
  logic      resp_fire;

  sync_fifo #(
    .ADDR_WIDTH (sram_pkg::ORDER_DEPTH_LOG2),
    .entry_t    (bank_idx_t)
  ) i_order_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_inc       (order_push),
    .w_data      (order_bank),
    .w_full      (order_full),
    .w_half_full (),
    .r_inc       (resp_fire),
    .r_empty     (order_empty),
    .r_data      (head)
  );

  assign order_ready = !order_full;

  // Oldest outstanding read picks the bank
  assign resp_valid   = !order_empty && bank_resp_valid[head];
  assign resp_rd_data = bank_resp_rd_data[head];
  assign resp_fire    = resp_valid && resp_ready;

  // Pop the head bank only, the others keep their data queued
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_resp_ready[i] = !order_empty && (head == bank_idx_t'(i)) && resp_ready;
    end
  end

  // Head bank may lag its order entry by at most the push cycle
  head_bank_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
      (!order_empty && !bank_resp_valid[head]) |-> $past(order_push)
  );

endmodule

// ==== verilog/banked_sram.sv ====
`timescale 1ns/1ns

module banked_sram #(
  parameter int                   ADDR_WIDTH = 6,
  parameter int                   BANK_BITS  = 2,
  parameter int                   DATA_WIDTH = 16,
  parameter sram_pkg::init_mode_e INIT_MODE  = sram_pkg::INIT_ADDR
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  logic [ADDR_WIDTH-1:0]   cmd_addr,
  input  logic                    cmd_wr_en,
  input  logic [DATA_WIDTH-1:0]   cmd_wr_data,
  input  logic [DATA_WIDTH/8-1:0] cmd_wr_strb,

  output logic                    resp_valid,
  input  logic                    resp_ready,
  output logic [DATA_WIDTH-1:0]   resp_rd_data
);

  localparam int NUM_BANKS        = 1 << BANK_BITS;
  localparam int LOCAL_ADDR_WIDTH = ADDR_WIDTH - BANK_BITS;

  logic [NUM_BANKS-1:0]                 bank_cmd_valid;
  logic [NUM_BANKS-1:0]                 bank_cmd_ready;
  logic [LOCAL_ADDR_WIDTH-1:0]          bank_cmd_addr;
  logic                                 order_push;
  logic [BANK_BITS-1:0]                 order_bank;
  logic                                 order_ready;
  logic [NUM_BANKS-1:0]                 bank_resp_valid;
  logic [NUM_BANKS-1:0]                 bank_resp_ready;
  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_resp_rd_data;

  bank_router #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BANK_BITS  (BANK_BITS),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_bank_router (
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_addr       (cmd_addr),
    .cmd_wr_en      (cmd_wr_en),
    .bank_cmd_valid (bank_cmd_valid),
    .bank_cmd_ready (bank_cmd_ready),
    .bank_cmd_addr  (bank_cmd_addr),
    .order_push     (order_push),
    .order_bank     (order_bank),
    .order_ready    (order_ready)
  );

  // Write data and strobe fan out to every bank
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    sram_bank #(
      .LOCAL_ADDR_WIDTH (LOCAL_ADDR_WIDTH),
      .BANK_BITS        (BANK_BITS),
      .BANK_INDEX       (i),
      .DATA_WIDTH       (DATA_WIDTH),
      .INIT_MODE        (INIT_MODE)
    ) i_sram_bank (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_valid    (bank_cmd_valid[i]),
      .cmd_ready    (bank_cmd_ready[i]),
      .cmd_addr     (bank_cmd_addr),
      .cmd_wr_en    (cmd_wr_en),
      .cmd_wr_data  (cmd_wr_data),
      .cmd_wr_strb  (cmd_wr_strb),
      .resp_valid   (bank_resp_valid[i]),
      .resp_ready   (bank_resp_ready[i]),
      .resp_rd_data (bank_resp_rd_data[i])
    );
  end

  resp_merger #(
    .BANK_BITS  (BANK_BITS),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_resp_merger (
    .clk               (clk),
    .rst_n             (rst_n),
    .order_push        (order_push),
    .order_bank        (order_bank),
    .order_ready       (order_ready),
    .bank_resp_valid   (bank_resp_valid),
    .bank_resp_ready   (bank_resp_ready),
    .bank_resp_rd_data (bank_resp_rd_data),
    .resp_valid        (resp_valid),
    .resp_ready        (resp_ready),
    .resp_rd_data      (resp_rd_data)
  );

endmodule

// ==== bench/tb_banked_sram.sv ====
`timescale 1ns/1ns

module tb_banked_sram;

  localparam int ADDR_WIDTH = 6;
  localparam int BANK_BITS  = 2;
  localparam int DATA_WIDTH = 16;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int WORDS      = 1 << ADDR_WIDTH;
  localparam int PERIOD     = 40;
  localparam int DRIVE_DLY  = 5;

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  logic  clk;
  logic  rst_n;
  logic  cmd_valid;
  logic  cmd_ready;
  addr_t cmd_addr;
  logic  cmd_wr_en;
  word_t cmd_wr_data;
  strb_t cmd_wr_strb;
  logic  resp_valid;
  logic  resp_ready;
  word_t resp_rd_data;

  // Test table, one entry per data file line
  string t_name  [$];
  byte   t_op    [$];
  addr_t t_addr  [$];
  word_t t_data  [$];
  strb_t t_strb  [$];
  word_t t_exp   [$];
  bit    t_model [$];

  word_t       model [WORDS]; // Memory image seen by the reads
  word_t       exp_q [$];
  string       exp_name_q [$];
  int          cycles;
  int          cycle_limit;
  int          pause_cycles;
  bit          pause_armed;
  bit          stall_seen;
  logic [31:0] lfsr;

  banked_sram i_banked_sram (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_addr     (cmd_addr),
    .cmd_wr_en    (cmd_wr_en),
    .cmd_wr_data  (cmd_wr_data),
    .cmd_wr_strb  (cmd_wr_strb),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp_rd_data (resp_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_rd_data(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    string       exp_s;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    fd = $fopen("bench/banked_sram_tests.txt", "r");
    if (fd == 0) begin
      stop_with_error("Cannot open the test file bench/banked_sram_tests.txt");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue; // Blank or comment
      end
      n = $sscanf(line, "%s %s %h %h %h %s", name, op, a, d, s, exp_s);
      if (n != 6) begin
        stop_with_error({"Malformed line in the test file: ", line});
      end
      e = '0;
      if (exp_s != "X" && exp_s != "-") begin
        void'($sscanf(exp_s, "%h", e));
      end
      t_name.push_back(name);
      t_op.push_back(op[0]);
      t_addr.push_back(addr_t'(a));
      t_data.push_back(word_t'(d));
      t_strb.push_back(strb_t'(s));
      t_exp.push_back(word_t'(e));
      t_model.push_back(exp_s == "X");
    end
    $fclose(fd);
    if (t_name.size() == 0) begin
      stop_with_error("The test file holds no tests");
    end
  endtask

  // Entered just after a drive point, returns one drive point after acceptance
  task automatic send_cmd(input int idx);
    bit accepted;
    cmd_valid   = 1'b1;
    cmd_addr    = t_addr[idx];
    cmd_wr_en   = (t_op[idx] == "W");
    cmd_wr_data = t_data[idx];
    cmd_wr_strb = t_strb[idx];
    accepted    = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = cmd_ready;
      if (!cmd_ready) begin
        stall_seen = 1'b1;
      end
      if (accepted && t_op[idx] == "W") begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (t_strb[idx][b]) begin
            model[t_addr[idx]][b*8 +: 8] = t_data[idx][b*8 +: 8];
          end
        end
      end else if (accepted) begin
        exp_q.push_back(t_model[idx] ? model[t_addr[idx]] : t_exp[idx]);
        exp_name_q.push_back(t_name[idx]);
      end
      @(posedge clk);
    end
    #DRIVE_DLY;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain(input string name);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_flag({name, "_resp_valid"}, 1'b0, resp_valid); // Nothing left over
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Response checker, samples mid-cycle
  always @(negedge clk) begin
    if (rst_n && resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        stop_with_error("A response arrived with no read outstanding");
      end else begin
        check_rd_data(exp_name_q[0], exp_q[0], resp_rd_data);
        void'(exp_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
  end

  initial begin : drive_resp_ready
    logic bit_a;
    logic bit_b;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      if (pause_cycles > 0) begin
        pause_cycles = pause_cycles - 1;
        bit_a = 1'b0;
        bit_b = 1'b0;
      end else begin
        lfsr  = lfsr_next(lfsr);
        bit_a = lfsr[0];
        lfsr  = lfsr_next(lfsr);
        bit_b = lfsr[0];
      end
      #DRIVE_DLY;
      resp_ready = bit_a | bit_b; // Ready about three cycles in four
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      stop_with_error($sformatf("Timeout after %0d cycles, the DUT stopped responding", cycles));
    end
  end

  initial begin
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_addr     = '0;
    cmd_wr_en    = 1'b0;
    cmd_wr_data  = '0;
    cmd_wr_strb  = '0;
    resp_ready   = 1'b0;
    lfsr         = 32'h1334_c75e;
    pause_cycles = 0;
    pause_armed  = 1'b0;
    stall_seen   = 1'b0;
    cycles       = 0;
    cycle_limit  = 0;
    for (int i = 0; i < WORDS; i++) begin
      model[i] = word_t'(i); // Every word starts as its own address
    end
    load_tests();
    cycle_limit = 40 * t_name.size() + 200;

    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("reset_resp_valid", 1'b0, resp_valid);
    check_flag("reset_cmd_ready", 1'b1, cmd_ready);
    @(posedge clk);
    #DRIVE_DLY;

    for (int i = 0; i < t_name.size(); i++) begin
      case (t_op[i])
        "W", "R": send_cmd(i);
        "D": begin
          if (t_data[i] != '0) begin
            pause_cycles = int'(t_data[i]); // Hold resp_ready low
            pause_armed  = 1'b1;
            stall_seen   = 1'b0;
            @(posedge clk);
            #DRIVE_DLY;
          end else begin
            wait_drain(t_name[i]);
            if (pause_armed && !stall_seen) begin
              stop_with_error({"cmd_ready never dropped while responses were held in ",
                               t_name[i]});
            end
            pause_armed = 1'b0;
          end
        end
        default: stop_with_error({"Unknown operation in test ", t_name[i]});
      endcase
    end
    wait_drain("final");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== bench/banked_sram_tests.txt ====
# Columns: name op addr data strb expected, numbers in hex
# op W write, R read, D with data > 0 holds resp_ready low that many cycles, D with data 0 drains
# expected X comes from the model, - means no read data
init_bank0 R 00 0000 0 0000
init_bank1 R 01 0000 0 0001
init_bank2 R 02 0000 0 0002
init_bank3 R 03 0000 0 0003
init_top R 3f 0000 0 003f
init_mid R 16 0000 0 X
drain_init D 00 0000 0 -
wr_full_b0 W 04 a5c3 3 -
rd_full_b0 R 04 0000 0 a5c3
wr_full_b1 W 09 1234 3 -
rd_full_b1 R 09 0000 0 1234
wr_full_b2 W 0e beef 3 -
wr_full_b3 W 13 cafe 3 -
rd_full_b2 R 0e 0000 0 beef
rd_full_b3 R 13 0000 0 cafe
wr_low_byte W 04 ff11 1 -
rd_low_byte R 04 0000 0 a511
wr_high_byte W 09 77ff 2 -
rd_high_byte R 09 0000 0 7734
wr_no_byte W 0e 0000 0 -
rd_no_byte R 0e 0000 0 beef
wr_high_init W 2b 9900 2 -
rd_high_init R 2b 0000 0 992b
drain_strb D 00 0000 0 -
ilv_0 R 10 0000 0 X
ilv_1 R 21 0000 0 X
ilv_2 R 32 0000 0 X
ilv_3 R 03 0000 0 X
ilv_4 R 04 0000 0 X
ilv_5 R 09 0000 0 X
ilv_6 R 0e 0000 0 X
ilv_7 R 13 0000 0 X
ilv_8 R 18 0000 0 X
ilv_9 R 29 0000 0 X
ilv_a R 3a 0000 0 X
ilv_b R 2b 0000 0 X
drain_ilv D 00 0000 0 -
hold_start D 00 0028 0 -
hold_b1_0 R 05 0000 0 X
hold_b1_1 R 09 0000 0 X
hold_b1_2 R 0d 0000 0 X
hold_b1_3 R 11 0000 0 X
hold_b2_0 R 02 0000 0 X
hold_drain D 00 0000 0 -
wr_last W 3f 0102 3 -
rd_last R 3f 0000 0 0102
rd_first R 00 0000 0 X

// ==== tb.f ====
verilog/sram_pkg.sv
verilog/sync_fifo.sv
verilog/sram_bank.sv
verilog/bank_router.sv
verilog/resp_merger.sv
verilog/banked_sram.sv
bench/tb_banked_sram.sv
